// ==== design/isa_pkg.sv ====
package isa_pkg;

   localparam int WORD_W    = 16;
   localparam int OPCODE_W  = 5;
   localparam int NUM_REGS  = 8;
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   typedef logic [WORD_W-1:0]    word_t;     // Data and instruction word
   typedef logic [OPCODE_W-1:0]  opcode_t;   // Major opcode, instr[15:11]
   typedef logic [REG_IDX_W-1:0] reg_idx_t;  // Register file index

   localparam word_t PC_STEP = word_t'(2);   // Byte-addressed 16-bit words

   // Major opcodes, 5'b00011 is left undefined
   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_SIIC  = 5'b00010;  // Exception not modelled
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_JR    = 5'b00101;
   localparam opcode_t OP_JAL   = 5'b00110;
   localparam opcode_t OP_JALR  = 5'b00111;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_SUBI  = 5'b01001;
   localparam opcode_t OP_XORI  = 5'b01010;
   localparam opcode_t OP_ANDNI = 5'b01011;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_BNEZ  = 5'b01101;
   localparam opcode_t OP_BLTZ  = 5'b01110;
   localparam opcode_t OP_BGEZ  = 5'b01111;
   localparam opcode_t OP_ST    = 5'b10000;
   localparam opcode_t OP_LD    = 5'b10001;
   localparam opcode_t OP_SLBI  = 5'b10010;
   localparam opcode_t OP_STU   = 5'b10011;
   localparam opcode_t OP_ROLI  = 5'b10100;
   localparam opcode_t OP_SLLI  = 5'b10101;
   localparam opcode_t OP_RORI  = 5'b10110;
   localparam opcode_t OP_SRLI  = 5'b10111;
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_BTR   = 5'b11001;
   localparam opcode_t OP_SHIFT = 5'b11010;  // ROL, SLL, ROR, SRL by instr[1:0]
   localparam opcode_t OP_ARITH = 5'b11011;  // ADD, SUB, XOR, ANDN by instr[1:0]
   localparam opcode_t OP_SEQ   = 5'b11100;
   localparam opcode_t OP_SLT   = 5'b11101;
   localparam opcode_t OP_SLE   = 5'b11110;
   localparam opcode_t OP_SCO   = 5'b11111;

endpackage

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

   typedef enum logic [2:0] {
      ALU_ROL  = 3'b000,
      ALU_SLL  = 3'b001,
      ALU_ROR  = 3'b010,
      ALU_SRL  = 3'b011,
      ALU_ADD  = 3'b100,
      ALU_ANDN = 3'b101,   // AND, B side inverted by the decoder
      ALU_BTR  = 3'b110,
      ALU_XOR  = 3'b111
   } alu_op_e;

   typedef enum logic [2:0] {
      WR_ALU  = 3'b000,
      WR_MEM  = 3'b001,    // Load data, owned by the external side
      WR_LINK = 3'b010,
      WR_SET  = 3'b011,
      WR_LBI  = 3'b100,
      WR_SLBI = 3'b101
   } wr_sel_e;

   typedef enum logic [1:0] {
      REG_4_2  = 2'b00,
      REG_7_5  = 2'b01,
      REG_10_8 = 2'b10,
      REG_R7   = 2'b11
   } wr_reg_sel_e;

   typedef enum logic [1:0] {
      SEXT_Z5  = 2'b00,
      SEXT_S5  = 2'b01,
      SEXT_S8  = 2'b10,
      SEXT_S11 = 2'b11
   } sext_op_e;

   typedef enum logic [1:0] {BR_ZERO, BR_NONZERO, BR_NEG, BR_NONNEG} br_cnd_e;

   typedef enum logic [1:0] {SET_CARRY, SET_EQ, SET_LT, SET_LE} set_sel_e;

   typedef enum logic {ST_RUN, ST_HALT} run_state_e;

endpackage

// ==== design/instr_intake.sv ====
module instr_intake import isa_pkg::*, ctrl_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  in_valid,
   output logic  in_ready,
   input  word_t in_instr,
   input  logic  halt,           // Held word decodes as HALT
   input  logic  release_held,   // Held word executes this cycle
   output logic  held_valid,
   output word_t held_instr
);

   run_state_e state;
   logic       started;          // Low through reset
   logic       accept;

   // A HALT leaving the slot must not let the next word in
   assign in_ready = started && (state == ST_RUN) &&
                     (!held_valid || (release_held && !halt));
   assign accept   = in_valid && in_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         started    <= 1'b0;
         state      <= ST_RUN;
         held_valid <= 1'b0;
      end else begin
         started <= 1'b1;
         if (accept) begin
            held_valid <= 1'b1;
         end else if (release_held) begin
            held_valid <= 1'b0;
         end
         case (state)
            ST_RUN: begin
               if (release_held && halt) begin
                  state <= ST_HALT;   // Only reset leaves this
               end
            end
            default: state <= ST_HALT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         held_instr <= in_instr;
      end
   end

   a_release_when_held: assert property (@(posedge clk) disable iff (reset)
      release_held |-> held_valid);

endmodule

// ==== design/control.sv ====
module control import isa_pkg::*, ctrl_pkg::*; (
   input  word_t       instr,
   output br_cnd_e     br_cnd_sel,
   output set_sel_e    set_sel,
   output logic        wr_en,
   output logic        mem_wr_en,
   output logic        mem_en,
   output wr_sel_e     wr_sel,
   output wr_reg_sel_e wr_reg_sel,
   output logic        oprnd_sel,
   output logic        jmp_reg_instr,
   output logic        jmp_instr,
   output logic        br_instr,
   output sext_op_e    sext_op,
   output alu_op_e     alu_op,
   output logic        alu_invA,
   output logic        alu_invB,
   output logic        alu_Cin,
   output logic        alu_sign,
   output logic        pc_en,
   output logic        err
);

   opcode_t opcode;

   assign opcode = instr[15:11];

   always_comb begin
      br_cnd_sel    = BR_ZERO;
      set_sel       = SET_CARRY;
      wr_en         = 1'b0;
      mem_wr_en     = 1'b0;
      mem_en        = 1'b0;
      wr_sel        = WR_ALU;
      wr_reg_sel    = REG_4_2;     // Rd of the R-format
      oprnd_sel     = 1'b0;        // Immediate as B operand
      jmp_reg_instr = 1'b0;
      jmp_instr     = 1'b0;
      br_instr      = 1'b0;
      sext_op       = SEXT_Z5;
      alu_op        = ALU_ROL;
      alu_invA      = 1'b0;
      alu_invB      = 1'b0;
      alu_Cin       = 1'b0;
      alu_sign      = 1'b1;        // Signed compare
      pc_en         = 1'b1;
      err           = 1'b0;

      case (opcode)
         OP_HALT: pc_en = 1'b0;
         OP_NOP, OP_SIIC: begin
         end
         OP_ADDI, OP_SUBI: begin
            wr_en      = 1'b1;
            wr_reg_sel = REG_7_5;
            oprnd_sel  = 1'b1;
            sext_op    = SEXT_S5;
            alu_op     = ALU_ADD;
            alu_invA   = opcode[0];   // SUBI is imm - Rs
            alu_Cin    = opcode[0];
         end
         OP_XORI, OP_ANDNI: begin
            wr_en      = 1'b1;
            wr_reg_sel = REG_7_5;
            oprnd_sel  = 1'b1;
            alu_op     = opcode[0] ? ALU_ANDN : ALU_XOR;
            alu_invB   = opcode[0];
         end
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            wr_en      = 1'b1;
            wr_reg_sel = REG_7_5;
            oprnd_sel  = 1'b1;
            alu_op     = alu_op_e'({1'b0, opcode[1:0]});
         end
         OP_ST, OP_LD, OP_STU: begin
            mem_en     = 1'b1;
            mem_wr_en  = (opcode != OP_LD);
            wr_en      = (opcode != OP_ST);
            wr_sel     = (opcode == OP_LD) ? WR_MEM : WR_ALU;
            wr_reg_sel = (opcode == OP_STU) ? REG_10_8 : REG_7_5;   // STU updates Rs
            oprnd_sel  = 1'b1;
            sext_op    = SEXT_S5;
            alu_op     = ALU_ADD;
         end
         OP_BTR: begin
            wr_en  = 1'b1;
            alu_op = ALU_BTR;
         end
         OP_ARITH: begin
            wr_en    = 1'b1;
            alu_op   = !instr[1] ? ALU_ADD : (!instr[0] ? ALU_XOR : ALU_ANDN);
            alu_invA = ~instr[1] & instr[0];
            alu_invB = instr[1] & instr[0];
            alu_Cin  = ~instr[1] & instr[0];
         end
         OP_SHIFT: begin
            wr_en  = 1'b1;
            alu_op = alu_op_e'({1'b0, instr[1:0]});
         end
         OP_SEQ, OP_SLT, OP_SLE: begin
            wr_en    = 1'b1;
            set_sel  = (opcode == OP_SEQ) ? SET_EQ : ((opcode == OP_SLT) ? SET_LT : SET_LE);
            wr_sel   = WR_SET;
            alu_op   = ALU_ADD;
            alu_invB = 1'b1;           // Rs - Rt
            alu_Cin  = 1'b1;
         end
         OP_SCO: begin
            wr_en    = 1'b1;
            wr_sel   = WR_SET;
            alu_sign = 1'b0;
            alu_op   = ALU_ADD;
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            br_cnd_sel = br_cnd_e'(opcode[1:0]);
            br_instr   = 1'b1;
            sext_op    = SEXT_S8;
         end
         OP_LBI, OP_SLBI: begin
            wr_en      = 1'b1;
            wr_sel     = (opcode == OP_LBI) ? WR_LBI : WR_SLBI;
            wr_reg_sel = REG_10_8;
         end
         OP_J, OP_JR, OP_JAL, OP_JALR: begin
            jmp_instr     = 1'b1;
            jmp_reg_instr = opcode[0];
            sext_op       = opcode[0] ? SEXT_S8 : SEXT_S11;
            wr_en         = opcode[1];    // JAL and JALR link
            wr_sel        = WR_LINK;
            wr_reg_sel    = REG_R7;
         end
         default: err = 1'b1;
      endcase
   end

endmodule

// ==== design/execute_unit.sv ====
module execute_unit import isa_pkg::*, ctrl_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  word_t       instr,
   input  br_cnd_e     br_cnd_sel,
   input  set_sel_e    set_sel,
   input  logic        wr_en,
   input  logic        mem_wr_en,
   input  logic        mem_en,
   input  wr_sel_e     wr_sel,
   input  wr_reg_sel_e wr_reg_sel,
   input  logic        oprnd_sel,
   input  logic        jmp_reg_instr,
   input  logic        jmp_instr,
   input  logic        br_instr,
   input  sext_op_e    sext_op,
   input  alu_op_e     alu_op,
   input  logic        alu_invA,
   input  logic        alu_invB,
   input  logic        alu_Cin,
   input  logic        alu_sign,
   input  logic        pc_en,
   input  logic        err,
   input  logic        held_valid,
   input  logic        stage_ready,
   output logic        exec_fire,
   output word_t       pc,
   output word_t       next_pc,
   output logic        wr_en_eff,
   output reg_idx_t    wr_reg,
   output word_t       wr_data,
   output word_t       mem_addr,
   output word_t       mem_data
);

   word_t              rf [NUM_REGS];
   word_t              rs_val, rt_val, imm, op_a, op_b, alu_res, btr_res, pc_inc;
   logic [WORD_W:0]    sum;            // Carry out on top
   logic [2*WORD_W-1:0] rol_dbl, ror_dbl;
   logic [3:0]         shamt;
   logic               carry, ovf, less, equal, set_bit, br_taken;

   assign rs_val = rf[instr[10:8]];
   assign rt_val = rf[instr[7:5]];

   always_comb begin
      case (sext_op)
         SEXT_Z5: imm = {11'b0, instr[4:0]};
         SEXT_S5: imm = {{11{instr[4]}}, instr[4:0]};
         SEXT_S8: imm = {{8{instr[7]}}, instr[7:0]};
         default: imm = {{5{instr[10]}}, instr[10:0]};
      endcase
   end

   assign op_a    = alu_invA ? ~rs_val : rs_val;
   assign op_b    = alu_invB ? ~(oprnd_sel ? imm : rt_val) : (oprnd_sel ? imm : rt_val);
   assign sum     = {1'b0, op_a} + {1'b0, op_b} + {{WORD_W{1'b0}}, alu_Cin};
   assign shamt   = op_b[3:0];
   assign rol_dbl = {op_a, op_a} << shamt;
   assign ror_dbl = {op_a, op_a} >> shamt;

   always_comb begin
      for (int i = 0; i < WORD_W; i++) begin
         btr_res[i] = op_a[WORD_W-1-i];
      end
   end

   always_comb begin
      case (alu_op)
         ALU_ROL:  alu_res = rol_dbl[2*WORD_W-1:WORD_W];
         ALU_SLL:  alu_res = op_a << shamt;
         ALU_ROR:  alu_res = ror_dbl[WORD_W-1:0];
         ALU_SRL:  alu_res = op_a >> shamt;
         ALU_ADD:  alu_res = sum[WORD_W-1:0];
         ALU_ANDN: alu_res = op_a & op_b;
         ALU_BTR:  alu_res = btr_res;
         default:  alu_res = op_a ^ op_b;
      endcase
   end

   // Set results from Rs + ~Rt + 1, or from Rs + Rt for SCO
   assign carry = sum[WORD_W];
   assign ovf   = (op_a[WORD_W-1] == op_b[WORD_W-1]) && (sum[WORD_W-1] != op_a[WORD_W-1]);
   assign less  = alu_sign ? (sum[WORD_W-1] ^ ovf) : ~carry;
   assign equal = (sum[WORD_W-1:0] == '0);

   always_comb begin
      case (set_sel)
         SET_CARRY: set_bit = carry;
         SET_EQ:    set_bit = equal;
         SET_LT:    set_bit = less;
         default:   set_bit = less | equal;
      endcase
   end

   always_comb begin
      case (br_cnd_sel)
         BR_ZERO:    br_taken = (rs_val == '0);
         BR_NONZERO: br_taken = (rs_val != '0);
         BR_NEG:     br_taken = rs_val[WORD_W-1];
         default:    br_taken = ~rs_val[WORD_W-1];
      endcase
   end

   assign pc_inc = pc + PC_STEP;

   always_comb begin
      if (!pc_en) begin
         next_pc = pc;                 // HALT holds the PC
      end else if (jmp_reg_instr) begin
         next_pc = rs_val + imm;
      end else if (jmp_instr || (br_instr && br_taken)) begin
         next_pc = pc_inc + imm;
      end else begin
         next_pc = pc_inc;
      end
   end

   always_comb begin
      case (wr_sel)
         WR_LINK: wr_data = pc_inc;
         WR_SET:  wr_data = {{(WORD_W-1){1'b0}}, set_bit};
         WR_LBI:  wr_data = {{8{instr[7]}}, instr[7:0]};
         WR_SLBI: wr_data = {rs_val[7:0], instr[7:0]};
         default: wr_data = alu_res;
      endcase
   end

   always_comb begin
      case (wr_reg_sel)
         REG_4_2:  wr_reg = instr[4:2];
         REG_7_5:  wr_reg = instr[7:5];
         REG_10_8: wr_reg = instr[10:8];
         default:  wr_reg = reg_idx_t'(NUM_REGS - 1);
      endcase
   end

   // Load data never comes back, so LD leaves the register file alone
   assign wr_en_eff = wr_en && !err && (wr_sel != WR_MEM);
   assign exec_fire = held_valid && stage_ready;
   assign mem_addr  = mem_en ? alu_res : '0;
   assign mem_data  = mem_wr_en ? rt_val : '0;   // Store data from Rd

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         for (int i = 0; i < NUM_REGS; i++) begin
            rf[i] <= '0;
         end
      end else if (exec_fire) begin
         pc <= next_pc;
         if (wr_en_eff) begin
            rf[wr_reg] <= wr_data;
         end
      end
   end

   a_fire_known: assert property (@(posedge clk) disable iff (reset)
      exec_fire |-> !$isunknown({next_pc, wr_en_eff, wr_reg, wr_data, mem_addr, mem_data}));

endmodule

// ==== design/commit_out.sv ====
module commit_out import isa_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     exec_fire,
   output logic     stage_ready,
   output logic     commit_valid,
   input  logic     commit_ready,
   input  word_t    pc,
   input  word_t    next_pc,
   input  logic     wr_en,
   input  reg_idx_t wr_reg,
   input  word_t    wr_data,
   input  logic     mem_en,
   input  logic     mem_wr,
   input  word_t    mem_addr,
   input  word_t    mem_data,
   input  logic     halt,
   input  logic     err,
   output word_t    commit_pc,
   output word_t    commit_next_pc,
   output logic     commit_wr_en,
   output reg_idx_t commit_wr_reg,
   output word_t    commit_wr_data,
   output logic     commit_mem_en,
   output logic     commit_mem_wr,
   output word_t    commit_mem_addr,
   output word_t    commit_mem_data,
   output logic     commit_halt,
   output logic     commit_err
);

   assign stage_ready = !commit_valid || commit_ready;   // Slot frees this edge

   always_ff @(posedge clk) begin
      if (reset) begin
         commit_valid <= 1'b0;
      end else if (exec_fire) begin
         commit_valid <= 1'b1;
      end else if (commit_ready) begin
         commit_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (exec_fire) begin
         commit_pc       <= pc;
         commit_next_pc  <= next_pc;
         commit_wr_en    <= wr_en;
         commit_wr_reg   <= wr_reg;
         commit_wr_data  <= wr_data;
         commit_mem_en   <= mem_en;
         commit_mem_wr   <= mem_wr;
         commit_mem_addr <= mem_addr;
         commit_mem_data <= mem_data;
         commit_halt     <= halt;
         commit_err      <= err;
      end
   end

   a_record_held: assert property (@(posedge clk) disable iff (reset)
      commit_valid && !commit_ready |=> commit_valid &&
         $stable({commit_pc, commit_next_pc, commit_wr_en, commit_wr_reg, commit_wr_data,
                  commit_mem_en, commit_mem_wr, commit_mem_addr, commit_mem_data,
                  commit_halt, commit_err}));

endmodule

// ==== design/wisc_core.sv ====
module wisc_core import isa_pkg::*, ctrl_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   output logic     in_ready,
   input  word_t    in_instr,
   input  logic     commit_ready,
   output logic     commit_valid,
   output word_t    commit_pc,
   output word_t    commit_next_pc,
   output logic     commit_wr_en,
   output reg_idx_t commit_wr_reg,
   output word_t    commit_wr_data,
   output logic     commit_mem_en,
   output logic     commit_mem_wr,
   output word_t    commit_mem_addr,
   output word_t    commit_mem_data,
   output logic     commit_halt,
   output logic     commit_err
);

   word_t       held_instr, pc, next_pc, wr_data, mem_addr, mem_data;
   logic        held_valid, exec_fire, stage_ready, wr_en_eff;
   reg_idx_t    wr_reg;
   br_cnd_e     br_cnd_sel;
   set_sel_e    set_sel;
   wr_sel_e     wr_sel;
   wr_reg_sel_e wr_reg_sel;
   sext_op_e    sext_op;
   alu_op_e     alu_op;
   logic        wr_en, mem_wr_en, mem_en, oprnd_sel, jmp_reg_instr, jmp_instr, br_instr;
   logic        alu_invA, alu_invB, alu_Cin, alu_sign, pc_en, err;

   instr_intake u_intake (
      .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
      .in_instr(in_instr), .halt(~pc_en), .release_held(exec_fire),
      .held_valid(held_valid), .held_instr(held_instr));

   control u_control (
      .instr(held_instr), .br_cnd_sel(br_cnd_sel), .set_sel(set_sel), .wr_en(wr_en),
      .mem_wr_en(mem_wr_en), .mem_en(mem_en), .wr_sel(wr_sel), .wr_reg_sel(wr_reg_sel),
      .oprnd_sel(oprnd_sel), .jmp_reg_instr(jmp_reg_instr), .jmp_instr(jmp_instr),
      .br_instr(br_instr), .sext_op(sext_op), .alu_op(alu_op), .alu_invA(alu_invA),
      .alu_invB(alu_invB), .alu_Cin(alu_Cin), .alu_sign(alu_sign), .pc_en(pc_en),
      .err(err));

   execute_unit u_exec (
      .clk(clk), .reset(reset), .instr(held_instr), .br_cnd_sel(br_cnd_sel),
      .set_sel(set_sel), .wr_en(wr_en), .mem_wr_en(mem_wr_en), .mem_en(mem_en),
      .wr_sel(wr_sel), .wr_reg_sel(wr_reg_sel), .oprnd_sel(oprnd_sel),
      .jmp_reg_instr(jmp_reg_instr), .jmp_instr(jmp_instr), .br_instr(br_instr),
      .sext_op(sext_op), .alu_op(alu_op), .alu_invA(alu_invA), .alu_invB(alu_invB),
      .alu_Cin(alu_Cin), .alu_sign(alu_sign), .pc_en(pc_en), .err(err),
      .held_valid(held_valid), .stage_ready(stage_ready), .exec_fire(exec_fire),
      .pc(pc), .next_pc(next_pc), .wr_en_eff(wr_en_eff), .wr_reg(wr_reg),
      .wr_data(wr_data), .mem_addr(mem_addr), .mem_data(mem_data));

   commit_out u_commit (
      .clk(clk), .reset(reset), .exec_fire(exec_fire), .stage_ready(stage_ready),
      .commit_valid(commit_valid), .commit_ready(commit_ready), .pc(pc),
      .next_pc(next_pc), .wr_en(wr_en_eff), .wr_reg(wr_reg), .wr_data(wr_data),
      .mem_en(mem_en), .mem_wr(mem_wr_en), .mem_addr(mem_addr), .mem_data(mem_data),
      .halt(~pc_en), .err(err), .commit_pc(commit_pc), .commit_next_pc(commit_next_pc),
      .commit_wr_en(commit_wr_en), .commit_wr_reg(commit_wr_reg),
      .commit_wr_data(commit_wr_data), .commit_mem_en(commit_mem_en),
      .commit_mem_wr(commit_mem_wr), .commit_mem_addr(commit_mem_addr),
      .commit_mem_data(commit_mem_data), .commit_halt(commit_halt),
      .commit_err(commit_err));

endmodule

// ==== verification/tb_core.sv ====
module tb_core import isa_pkg::*; ();

   localparam int          MAX_LINES  = 64;
   localparam int          NUM_FIELDS = 12;
   localparam int          CYC_PER_LN = 20;        // Timeout budget per instruction
   localparam logic [31:0] SEED       = 32'h67d1;
   localparam string       STIM_FILE  = "verification/core_stim.txt";

   // Column order of the stimulus file
   localparam int F_INSTR = 0, F_PC = 1, F_NEXT = 2, F_WR_EN = 3, F_WR_REG = 4, F_WR_DATA = 5;
   localparam int F_MEM_EN = 6, F_MEM_WR = 7, F_ADDR = 8, F_DATA = 9, F_HALT = 10, F_ERR = 11;

   logic     clk, reset, in_valid, in_ready, commit_ready, commit_valid;
   word_t    in_instr, commit_pc, commit_next_pc, commit_wr_data, commit_mem_addr;
   word_t    commit_mem_data;
   logic     commit_wr_en, commit_mem_en, commit_mem_wr, commit_halt, commit_err;
   reg_idx_t commit_wr_reg;

   logic [15:0] stim [MAX_LINES][NUM_FIELDS];
   int          num_lines, send_idx, cur_idx, recv_count, errors, cycle_count, timeout_limit;
   int          exp_q[$];                          // Indices of accepted instructions
   bit          in_fire, halt_seen, load_ok;

   wisc_core dut (
      .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
      .in_instr(in_instr), .commit_ready(commit_ready), .commit_valid(commit_valid),
      .commit_pc(commit_pc), .commit_next_pc(commit_next_pc), .commit_wr_en(commit_wr_en),
      .commit_wr_reg(commit_wr_reg), .commit_wr_data(commit_wr_data),
      .commit_mem_en(commit_mem_en), .commit_mem_wr(commit_mem_wr),
      .commit_mem_addr(commit_mem_addr), .commit_mem_data(commit_mem_data),
      .commit_halt(commit_halt), .commit_err(commit_err));

   always #5 clk = ~clk;

   task automatic load_stimulus(output bit ok);
      int          fd;
      int          n;
      string       line;
      logic [15:0] f [NUM_FIELDS];
      num_lines = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file %s", STIM_FILE);
         ok = 1'b0;
      end else begin
         while (!$feof(fd) && num_lines < MAX_LINES) begin
            if ($fgets(line, fd) > 0) begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                           f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
               if (n == NUM_FIELDS) begin   // Comment and blank lines fall through
                  for (int k = 0; k < NUM_FIELDS; k++) begin
                     stim[num_lines][k] = f[k];
                  end
                  num_lines++;
               end
            end
         end
         $fclose(fd);
         ok = (num_lines > 0);
         if (!ok) begin
            $display("Stimulus file %s holds no records", STIM_FILE);
         end
      end
   endtask

   task automatic compare_field(input string name, input int idx, input logic [15:0] got,
                                input logic [15:0] exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at time %0t: %s of record %0d (instr %h) is %h, expected %h",
                  $time, name, idx, stim[idx][F_INSTR], got, exp);
      end
   endtask

   // Stimulus and back-pressure, driven on the rising edge
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (!reset) begin
         if (!in_valid || in_fire) begin
            if (send_idx < num_lines && ($urandom % 4) != 0) begin
               in_valid <= 1'b1;
               in_instr <= stim[send_idx][F_INSTR];
               cur_idx  <= send_idx;
               send_idx <= send_idx + 1;
            end else begin
               in_valid <= 1'b0;
            end
         end
         commit_ready <= (($urandom % 10) < 7);   // About 70 percent ready
      end
   end

   // Outputs sampled mid-cycle, where they are settled
   always @(negedge clk) begin
      int idx;
      in_fire = in_valid && in_ready;
      if (reset) begin
         if (cycle_count > 0 && (in_ready || commit_valid)) begin
            errors++;
            $display("** Error at time %0t: in_ready or commit_valid high during reset", $time);
         end
      end else begin
         if (in_fire) begin
            exp_q.push_back(cur_idx);
         end
         if (halt_seen && in_ready) begin
            errors++;
            $display("** Error at time %0t: in_ready is high after HALT committed", $time);
         end
         if (commit_valid && commit_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("A commit record appeared at time %0t with no instruction outstanding",
                        $time);
            end else begin
               idx = exp_q.pop_front();
               compare_field("pc", idx, commit_pc, stim[idx][F_PC]);
               compare_field("next_pc", idx, commit_next_pc, stim[idx][F_NEXT]);
               compare_field("wr_en", idx, 16'(commit_wr_en), stim[idx][F_WR_EN]);
               if (stim[idx][F_WR_EN][0]) begin   // Write fields only mean something here
                  compare_field("wr_reg", idx, 16'(commit_wr_reg), stim[idx][F_WR_REG]);
                  compare_field("wr_data", idx, commit_wr_data, stim[idx][F_WR_DATA]);
               end
               compare_field("mem_en", idx, 16'(commit_mem_en), stim[idx][F_MEM_EN]);
               compare_field("mem_wr", idx, 16'(commit_mem_wr), stim[idx][F_MEM_WR]);
               if (stim[idx][F_MEM_EN][0]) begin
                  compare_field("mem_addr", idx, commit_mem_addr, stim[idx][F_ADDR]);
               end
               if (stim[idx][F_MEM_WR][0]) begin
                  compare_field("mem_data", idx, commit_mem_data, stim[idx][F_DATA]);
               end
               compare_field("halt", idx, 16'(commit_halt), stim[idx][F_HALT]);
               compare_field("err", idx, 16'(commit_err), stim[idx][F_ERR]);
               recv_count++;
               if (commit_halt) begin
                  halt_seen = 1'b1;
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
         $display("Timeout after %0d cycles without a HALT commit", cycle_count);
         $display("%0d of %0d records checked, %0d errors", recv_count, num_lines, errors);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      in_valid     = 1'b0;
      in_instr     = '0;
      commit_ready = 1'b0;
      void'($urandom(SEED));
      load_stimulus(load_ok);
      if (!load_ok) begin
         $display("Simulation failed");
         $finish;
      end else begin
         timeout_limit = num_lines * CYC_PER_LN;
         repeat (16) @(posedge clk);
         reset <= 1'b0;
         wait (halt_seen);
         repeat (20) @(posedge clk);   // Watch in_ready stay low
         if (recv_count != num_lines) begin
            errors++;
            $display("Only %0d of %0d records were committed", recv_count, num_lines);
         end
         $display("%0d of %0d records checked, %0d errors", recv_count, num_lines, errors);
         if (errors == 0) begin
            $display("Simulation completed successfully");
         end else begin
            $display("Simulation failed");
         end
         $finish;
      end
   end

endmodule

// ==== verification/core_stim.txt ====
# instr pc next_pc wr_en wr_reg wr_data mem_en mem_wr mem_addr mem_data halt err, all hex
# wr_reg and wr_data count only with wr_en set, mem_addr with mem_en, mem_data with mem_wr
c134 0000 0002 1 1 0034 0 0 0000 0000 0 0  # lbi r1, 0x34
9112 0002 0004 1 1 3412 0 0 0000 0000 0 0  # slbi r1, 0x12
c2f0 0004 0006 1 2 fff0 0 0 0000 0000 0 0  # lbi r2, 0xf0
c305 0006 0008 1 3 0005 0 0 0000 0000 0 0  # lbi r3, 0x05
d970 0008 000a 1 4 3417 0 0 0000 0000 0 0  # add r4, r1, r3
da75 000a 000c 1 5 0015 0 0 0000 0000 0 0  # sub r5, r2, r3 gives r3 - r2
d95a 000c 000e 1 6 cbe2 0 0 0000 0000 0 0  # xor r6, r1, r2
d95f 000e 0010 1 7 0002 0 0 0000 0000 0 0  # andn r7, r1, r2
419d 0010 0012 1 4 340f 0 0 0000 0000 0 0  # addi r4, r1, -3
4ba7 0012 0014 1 5 0002 0 0 0000 0000 0 0  # subi r5, r3, 7 gives 7 - r3
51df 0014 0016 1 6 340d 0 0 0000 0000 0 0  # xori r6, r1, 0x1f
5af1 0016 0018 1 7 ffe0 0 0 0000 0000 0 0  # andni r7, r2, 0x11
a184 0018 001a 1 4 4123 0 0 0000 0000 0 0  # roli r4, r1, 4
baa3 001a 001c 1 5 1ffe 0 0 0000 0000 0 0  # srli r5, r2, 3
b1c4 001c 001e 1 6 2341 0 0 0000 0000 0 0  # rori r6, r1, 4
d171 001e 0020 1 4 8240 0 0 0000 0000 0 0  # sll r4, r1, r3
cb14 0020 0022 1 5 a000 0 0 0000 0000 0 0  # btr r5, r3
ea78 0022 0024 1 6 0001 0 0 0000 0000 0 0  # slt r6, r2, r3
e37c 0024 0026 1 7 0001 0 0 0000 0000 0 0  # seq r7, r3, r3
f958 0026 0028 1 6 0001 0 0 0000 0000 0 0  # sco r6, r1, r2
f174 0028 002a 1 5 0000 0 0 0000 0000 0 0  # sle r5, r1, r3
6508 002a 0034 0 0 0000 0 0 0000 0000 0 0  # beqz r5, 8 taken
7110 0034 0036 0 0 0000 0 0 0000 0000 0 0  # bltz r1, 16 not taken
6afc 0036 0034 0 0 0000 0 0 0000 0000 0 0  # bnez r2, -4 taken
2010 0034 0046 0 0 0000 0 0 0000 0000 0 0  # j 0x10
37fa 0046 0042 1 7 0048 0 0 0000 0000 0 0  # jal -6
2b20 0042 0025 0 0 0000 0 0 0000 0000 0 0  # jr r3, 0x20
3c04 0025 8244 1 7 0027 0 0 0000 0000 0 0  # jalr r4, 4
8162 8244 8246 0 0 0000 1 1 3414 0005 0 0  # st r3, r1, 2
8ade 8246 8248 0 0 0000 1 0 ffee 0000 0 0  # ld r6, r2, -2
99fc 8248 824a 1 1 340e 1 1 340e 0027 0 0  # stu r7, r1, -4
1abc 824a 824c 0 0 0000 0 0 0000 0000 0 1  # undefined opcode 00011
4141 824c 824e 1 2 340f 0 0 0000 0000 0 0  # addi r2, r1, 1
0800 824e 8250 0 0 0000 0 0 0000 0000 0 0  # nop
0000 8250 8250 0 0 0000 0 0 0000 0000 1 0  # halt

// ==== flist.f ====
design/isa_pkg.sv
design/ctrl_pkg.sv
design/instr_intake.sv
design/control.sv
design/execute_unit.sv
design/commit_out.sv
design/wisc_core.sv
verification/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
